//--- design/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;

    // Z register, hi word on top
    typedef struct packed {
        wordT hi;
        wordT lo;
    } dwordT;

    typedef enum logic [4:0] {
        opAdd = 5'b00011,
        opSub = 5'b00100,
        opAnd = 5'b00101,
        opOr  = 5'b00110,
        opShr = 5'b00111,
        opShl = 5'b01000,
        opMul = 5'b01111,
        opDiv = 5'b10000,
        opNeg = 5'b10001,
        opNot = 5'b10010
    } opcodeT;

    // register format, three register fields
    typedef struct packed {
        opcodeT      opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [14:0] unused;
    } rFormatT;

    // immediate format, constant is sign extended for Cout
    typedef struct packed {
        opcodeT      opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [18:0] imm;
    } iFormatT;

    typedef union packed {
        rFormatT rFormat;
        iFormatT iFormat;
    } instrT;

endpackage

//--- design/busPkg.sv
package busPkg;

    // one-hot strobes from the sequencer
    typedef struct packed {
        logic [15:0] regIn;
        logic [15:0] regOut;
        logic        pcIn;
        logic        pcOut;
        logic        incPc;   // pc + 4
        logic        marIn;
        logic        mdrIn;
        logic        mdrOut;
        logic        read;    // mdr takes memory data
        logic        irIn;
        logic        yIn;
        logic        zIn;     // also starts the alu
        logic        zLowOut;
        logic        zHighOut;
        logic        hiIn;
        logic        hiOut;
        logic        loIn;
        logic        loOut;
        logic        cOut;    // immediate of IR onto bus
    } ctrlT;

    typedef struct packed {
        logic busy;
        logic done;
    } statusT;

endpackage

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic         clk,
    input  logic         rstN,
    input  logic [15:0]  regIn,
    input  logic [15:0]  regOut,
    input  cpuPkg::wordT busIn,
    output cpuPkg::wordT readData
);

    cpuPkg::wordT regs [16];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // every strobed register takes the bus
            for (int i = 0; i < 16; i++) begin
                if (regIn[i]) begin
                    regs[i] <= busIn;
                end
            end
        end
    end

    // one-hot read, zero when nothing selected
    always_comb begin
        readData = '0;
        for (int i = 0; i < 16; i++) begin
            if (regOut[i]) begin
                readData = readData | regs[i];
            end
        end
    end

endmodule

//--- design/arithUnit.sv
`timescale 1ns/1ps

module arithUnit (
    input  cpuPkg::wordT   opA,
    input  cpuPkg::wordT   opB,
    input  cpuPkg::opcodeT opcode,
    output cpuPkg::wordT   result
);

    logic [4:0] shAmt;

    assign shAmt = opB[4:0];   // low bits only

    always_comb begin
        case (opcode)
            cpuPkg::opAdd: begin
                result = opA + opB;
            end
            cpuPkg::opSub: begin
                result = opA - opB;
            end
            cpuPkg::opAnd: begin
                result = opA & opB;
            end
            cpuPkg::opOr: begin
                result = opA | opB;
            end
            cpuPkg::opShr: begin
                result = opA >> shAmt;   // logical
            end
            cpuPkg::opShl: begin
                result = opA << shAmt;
            end
            cpuPkg::opNeg: begin
                result = -opB;
            end
            cpuPkg::opNot: begin
                result = ~opB;
            end
            default: begin
                // mul and div come from the iterative unit
                result = '0;
            end
        endcase
    end

endmodule

//--- design/mulDivUnit.sv
`timescale 1ns/1ps

module mulDivUnit (
    input  logic          clk,
    input  logic          rstN,
    input  logic          start,
    input  logic          isDiv,
    input  cpuPkg::wordT  opA,
    input  cpuPkg::wordT  opB,
    output cpuPkg::dwordT result,
    output logic          finish
);

    logic         running;
    logic [4:0]   count;
    logic         load;

    logic         isDivR;
    logic         negRes;    // signs of operands differ
    logic         negRem;    // dividend negative
    logic         divZero;
    cpuPkg::wordT divisor;   // |opB|, multiplicand or divisor
    cpuPkg::wordT hiAcc;     // partial product high / remainder
    cpuPkg::wordT loAcc;     // multiplier bits / quotient bits

    cpuPkg::wordT magA;
    cpuPkg::wordT magB;
    logic [32:0]  addSum;
    cpuPkg::wordT remShift;
    logic [32:0]  subDiff;
    logic [63:0]  product;
    cpuPkg::wordT quot;
    cpuPkg::wordT rem;

    assign load = start && !running;

    assign magA = opA[31] ? -opA : opA;
    assign magB = opB[31] ? -opB : opB;

    // multiply step, add then shift right
    assign addSum = loAcc[0] ? {1'b0, hiAcc} + {1'b0, divisor} : {1'b0, hiAcc};

    // restoring divide step, remainder stays below divisor so bit 31 is free
    assign remShift = {hiAcc[30:0], loAcc[31]};
    assign subDiff  = {1'b0, remShift} - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            running <= 1'b0;
            count   <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (load) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 5'd1;
                if (count == 5'd31) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            isDivR  <= isDiv;
            negRes  <= opA[31] ^ opB[31];
            negRem  <= opA[31];
            divZero <= (opB == '0);
            divisor <= magB;
            hiAcc   <= '0;
            loAcc   <= magA;
        end else if (running) begin
            if (isDivR) begin
                if (!subDiff[32]) begin   // no borrow, keep difference
                    hiAcc <= subDiff[31:0];
                    loAcc <= {loAcc[30:0], 1'b1};
                end else begin
                    hiAcc <= remShift;
                    loAcc <= {loAcc[30:0], 1'b0};
                end
            end else begin
                hiAcc <= addSum[32:1];
                loAcc <= {addSum[0], loAcc[31:1]};
            end
        end
    end

    assign product = {hiAcc, loAcc};
    assign quot    = divZero ? '1 : (negRes ? -loAcc : loAcc);
    assign rem     = negRem ? -hiAcc : hiAcc;   // sign of dividend

    always_comb begin
        if (isDivR) begin
            result.hi = rem;
            result.lo = quot;
        end else begin
            result = negRes ? -product : product;
        end
    end

endmodule

//--- design/aluCore.sv
`timescale 1ns/1ps

module aluCore (
    input  logic           clk,
    input  logic           rstN,
    input  logic           start,
    input  cpuPkg::opcodeT opcode,
    input  cpuPkg::wordT   opA,
    input  cpuPkg::wordT   opB,
    output cpuPkg::dwordT  zValue,
    output busPkg::statusT status
);

    logic          busy;
    logic          done;
    logic          accept;
    logic          isMulDiv;
    logic          mdStart;
    logic          mdFinish;
    cpuPkg::wordT  arithResult;
    cpuPkg::dwordT mdResult;

    assign isMulDiv = (opcode == cpuPkg::opMul) || (opcode == cpuPkg::opDiv);
    assign accept   = start && !busy;   // zIn while busy is dropped
    assign mdStart  = accept && isMulDiv;

    arithUnit uArith (
        .opA    (opA),
        .opB    (opB),
        .opcode (opcode),
        .result (arithResult)
    );

    mulDivUnit uMulDiv (
        .clk    (clk),
        .rstN   (rstN),
        .start  (mdStart),
        .isDiv  (opcode == cpuPkg::opDiv),
        .opA    (opA),
        .opB    (opB),
        .result (mdResult),
        .finish (mdFinish)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            zValue <= '0;
            busy   <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (mdFinish) begin
                zValue <= mdResult;
                busy   <= 1'b0;
                done   <= 1'b1;
            end else if (accept) begin
                if (isMulDiv) begin
                    busy <= 1'b1;
                end else begin
                    zValue <= {{32{arithResult[31]}}, arithResult};
                    done   <= 1'b1;
                end
            end
        end
    end

    assign status.busy = busy;
    assign status.done = done;

endmodule

//--- design/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic           clk,
    input  logic           rstN,
    input  busPkg::ctrlT   ctrl,
    input  cpuPkg::wordT   mDataIn,
    output cpuPkg::wordT   bus,
    output cpuPkg::wordT   mar,
    output busPkg::statusT status
);

    cpuPkg::wordT  pc;
    cpuPkg::wordT  mdr;
    cpuPkg::instrT ir;
    cpuPkg::wordT  y;
    cpuPkg::wordT  hi;
    cpuPkg::wordT  lo;
    cpuPkg::wordT  regData;
    cpuPkg::wordT  immExt;
    cpuPkg::dwordT zValue;

    regFile uRegs (
        .clk      (clk),
        .rstN     (rstN),
        .regIn    (ctrl.regIn),
        .regOut   (ctrl.regOut),
        .busIn    (bus),
        .readData (regData)
    );

    aluCore uAlu (
        .clk    (clk),
        .rstN   (rstN),
        .start  (ctrl.zIn),
        .opcode (ir.rFormat.opcode),
        .opA    (y),
        .opB    (bus),
        .zValue (zValue),
        .status (status)
    );

    assign immExt = {{13{ir.iFormat.imm[18]}}, ir.iFormat.imm};

    // one-hot bus mux, zero when idle
    always_comb begin
        bus = regData;
        if (ctrl.pcOut) begin
            bus = bus | pc;
        end
        if (ctrl.mdrOut) begin
            bus = bus | mdr;
        end
        if (ctrl.zLowOut) begin
            bus = bus | zValue.lo;
        end
        if (ctrl.zHighOut) begin
            bus = bus | zValue.hi;
        end
        if (ctrl.hiOut) begin
            bus = bus | hi;
        end
        if (ctrl.loOut) begin
            bus = bus | lo;
        end
        if (ctrl.cOut) begin
            bus = bus | immExt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc  <= '0;
            mar <= '0;
            mdr <= '0;
            ir  <= '0;
            y   <= '0;
            hi  <= '0;
            lo  <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pc <= bus;
            end else if (ctrl.incPc) begin
                pc <= pc + 32'd4;
            end
            if (ctrl.marIn) mar <= bus;
            if (ctrl.mdrIn) begin
                mdr <= ctrl.read ? mDataIn : bus;   // memory read wins
            end
            if (ctrl.irIn) ir <= bus;
            if (ctrl.yIn) y <= bus;
            if (ctrl.hiIn) hi <= bus;
            if (ctrl.loIn) lo <= bus;
        end
    end

endmodule

//--- dv/datapathTb.sv
`timescale 1ns/1ps

module datapathTb;

    logic           clk;
    logic           rstN;
    busPkg::ctrlT   ctrl;
    cpuPkg::wordT   mDataIn;
    cpuPkg::wordT   bus;
    cpuPkg::wordT   mar;
    busPkg::statusT status;

    // results waiting for the checker
    string         chkName [$];
    cpuPkg::dwordT chkExp [$];
    cpuPkg::dwordT chkAct [$];

    datapath datapath_i (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .mDataIn (mDataIn),
        .bus     (bus),
        .mar     (mar),
        .status  (status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected Z from opcode and operands
    function automatic cpuPkg::dwordT refResult(cpuPkg::opcodeT op, cpuPkg::wordT a,
                                                cpuPkg::wordT b);
        longint        sa;
        longint        sb;
        longint        prod;
        longint        quo;
        longint        md;
        cpuPkg::wordT  w;
        cpuPkg::dwordT r;
        sa = $signed(a);
        sb = $signed(b);
        w = '0;
        r = '0;
        if (op == cpuPkg::opMul) begin
            prod = sa * sb;
            r = prod;
        end else if (op == cpuPkg::opDiv) begin
            if (b == '0) begin
                r.hi = a;
                r.lo = '1;
            end else begin
                quo = sa / sb;   // truncates toward zero
                md = sa % sb;
                r.hi = md[31:0];
                r.lo = quo[31:0];
            end
        end else begin
            case (op)
                cpuPkg::opAdd: w = a + b;
                cpuPkg::opSub: w = a - b;
                cpuPkg::opAnd: w = a & b;
                cpuPkg::opOr:  w = a | b;
                cpuPkg::opShr: w = a >> b[4:0];
                cpuPkg::opShl: w = a << b[4:0];
                cpuPkg::opNeg: w = -b;
                default:       w = ~b;
            endcase
            r.lo = w;
            r.hi = w[31] ? '1 : '0;   // all ones for a negative result
        end
        return r;
    endfunction

    task automatic checkWord(string name, cpuPkg::wordT exp, cpuPkg::wordT act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkDword(string name, cpuPkg::dwordT exp, cpuPkg::dwordT act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkStatus(string name, busPkg::statusT exp, busPkg::statusT act);
        if (act !== exp) begin
            $display("mismatch %s expected %b actual %b", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkLatency(string name, int exp, int act);
        if (act != exp) begin
            $display("mismatch %s expected %0d actual %0d", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic expectResult(string name, cpuPkg::dwordT exp, cpuPkg::dwordT act);
        chkName.push_back(name);
        chkExp.push_back(exp);
        chkAct.push_back(act);
    endtask

    always @(negedge clk) begin
        while (chkExp.size() > 0) begin
            checkDword(chkName.pop_front(), chkExp.pop_front(), chkAct.pop_front());
        end
    end

    task automatic driveCycle(busPkg::ctrlT c);
        @(posedge clk);
        ctrl <= c;
    endtask

    task automatic readReg(busPkg::ctrlT c, output cpuPkg::wordT value);
        driveCycle(c);
        @(negedge clk);
        value = bus;
    endtask

    task automatic loadReg(int idx, cpuPkg::wordT value);
        busPkg::ctrlT c;
        c = '0;
        c.mdrIn = 1'b1;
        c.read = 1'b1;
        @(posedge clk);
        ctrl <= c;
        mDataIn <= value;
        c = '0;
        c.mdrOut = 1'b1;
        c.regIn[idx] = 1'b1;
        driveCycle(c);
        driveCycle('0);
    endtask

    task automatic fetch(cpuPkg::instrT instr, output cpuPkg::wordT marSeen);
        busPkg::ctrlT c;
        c = '0;
        c.pcOut = 1'b1;
        c.marIn = 1'b1;
        c.incPc = 1'b1;
        driveCycle(c);   // T0
        c = '0;
        c.mdrIn = 1'b1;
        c.read = 1'b1;
        @(posedge clk);   // T1
        ctrl <= c;
        mDataIn <= instr;
        @(negedge clk);
        marSeen = mar;
        c = '0;
        c.mdrOut = 1'b1;
        c.irIn = 1'b1;
        driveCycle(c);   // T2
        driveCycle('0);
    endtask

    // returns right at the zIn edge
    task automatic startOp(cpuPkg::opcodeT op, int ra, int rb);
        cpuPkg::instrT instr;
        cpuPkg::wordT  marSeen;
        busPkg::ctrlT  c;
        instr = '0;
        instr.rFormat.opcode = op;
        fetch(instr, marSeen);
        c = '0;
        c.regOut[ra] = 1'b1;
        c.yIn = 1'b1;
        driveCycle(c);
        c = '0;
        c.regOut[rb] = 1'b1;
        c.zIn = 1'b1;
        driveCycle(c);
        driveCycle('0);
    endtask

    task automatic waitDone(output int cycles);
        cycles = 1;
        @(negedge clk);
        while (status.done !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (status.done !== 1'b1) begin
            $display("timeout while waiting for done after the zIn edge");
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic readZ(output cpuPkg::dwordT z);
        busPkg::ctrlT c;
        cpuPkg::wordT loWord;
        cpuPkg::wordT hiWord;
        c = '0;
        c.zLowOut = 1'b1;
        c.loIn = 1'b1;
        driveCycle(c);
        c = '0;
        c.zHighOut = 1'b1;
        c.hiIn = 1'b1;
        driveCycle(c);
        c = '0;
        c.loOut = 1'b1;
        readReg(c, loWord);
        c = '0;
        c.hiOut = 1'b1;
        readReg(c, hiWord);
        z = {hiWord, loWord};
    endtask

    task automatic execute(cpuPkg::opcodeT op, int ra, int rb, output cpuPkg::dwordT z,
                           output int cycles);
        startOp(op, ra, rb);
        waitDone(cycles);
        readZ(z);
    endtask

    initial begin
        cpuPkg::dwordT  z;
        cpuPkg::wordT   a;
        cpuPkg::wordT   b;
        cpuPkg::wordT   w;
        cpuPkg::instrT  instr;
        busPkg::ctrlT   c;
        busPkg::statusT st;
        int             cycles;
        cpuPkg::opcodeT ops [8];
        logic [18:0]    imms [2];
        cpuPkg::wordT   immExp [2];
        void'($urandom(44));
        rstN <= 1'b0;
        ctrl <= '0;
        mDataIn <= '0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        st = '0;
        checkStatus("status after reset", st, status);
        for (int i = 0; i < 16; i++) begin
            c = '0;
            c.regOut[i] = 1'b1;
            readReg(c, w);
            checkWord($sformatf("R%0d after reset", i), '0, w);
        end
        a = $urandom;
        loadReg(2, 32'd16);
        loadReg(3, 32'hFFFF_FFFE);
        loadReg(7, a);
        c = '0;
        c.regOut[2] = 1'b1;
        readReg(c, w);
        checkWord("R2 readback", 32'd16, w);
        c = '0;
        c.regOut[3] = 1'b1;
        readReg(c, w);
        checkWord("R3 readback", 32'hFFFF_FFFE, w);
        c = '0;
        c.regOut[7] = 1'b1;
        readReg(c, w);
        checkWord("R7 readback", a, w);

        execute(cpuPkg::opDiv, 2, 3, z, cycles);
        checkWord("div 16 by -2 quotient", 32'hFFFF_FFF8, z.lo);
        checkWord("div 16 by -2 remainder", 32'h0, z.hi);
        checkLatency("div done delay", 34, cycles);
        for (int i = 0; i < 200; i++) begin
            a = $urandom;
            if (i % 8 == 0) begin
                b = '0;
            end else if (i % 8 == 1) begin
                b = ($urandom % 17) - 8;   // small divisors
            end else begin
                b = $urandom;
            end
            loadReg(4, a);
            loadReg(5, b);
            execute(cpuPkg::opDiv, 4, 5, z, cycles);
            expectResult($sformatf("div %h by %h", a, b), refResult(cpuPkg::opDiv, a, b), z);
        end

        for (int i = 0; i < 40; i++) begin
            a = $urandom;
            b = (i % 4 == 0) ? ($urandom % 64) - 32 : $urandom;
            loadReg(4, a);
            loadReg(5, b);
            loadReg(6, $urandom);
            startOp(cpuPkg::opMul, 4, 5);
            @(negedge clk);
            st.busy = 1'b1;
            st.done = 1'b0;
            checkStatus("status during mul", st, status);
            // single-cycle opcode in IR while mul runs
            instr = '0;
            instr.rFormat.opcode = cpuPkg::opAdd;
            fetch(instr, w);
            c = '0;
            c.regOut[6] = 1'b1;
            c.zIn = 1'b1;
            driveCycle(c);   // must be dropped
            driveCycle('0);
            waitDone(cycles);
            checkLatency("mul done delay", 34, cycles + 6);
            readZ(z);
            expectResult($sformatf("mul %h by %h", a, b), refResult(cpuPkg::opMul, a, b), z);
        end

        ops = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                cpuPkg::opShr, cpuPkg::opShl, cpuPkg::opNeg, cpuPkg::opNot};
        foreach (ops[k]) begin
            for (int i = 0; i < 12; i++) begin
                a = $urandom;
                b = $urandom;
                loadReg(4, a);
                loadReg(5, b);
                execute(ops[k], 4, 5, z, cycles);
                checkLatency($sformatf("%s done delay", ops[k].name()), 1, cycles);
                expectResult($sformatf("%s %h %h", ops[k].name(), a, b),
                             refResult(ops[k], a, b), z);
            end
        end

        // fetch from a known pc
        loadReg(1, 32'h100);
        c = '0;
        c.regOut[1] = 1'b1;
        c.pcIn = 1'b1;
        driveCycle(c);
        driveCycle('0);
        imms[0] = 19'h1_2345;
        imms[1] = 19'h7_FF9C;   // negative
        immExp[0] = 32'h0001_2345;
        immExp[1] = 32'hFFFF_FF9C;
        for (int k = 0; k < 2; k++) begin
            instr = '0;
            instr.iFormat.opcode = cpuPkg::opAdd;
            instr.iFormat.ra = 4'd1;
            instr.iFormat.imm = imms[k];
            fetch(instr, w);
            checkWord("mar after T0", 32'h100 + 4 * k, w);
            c = '0;
            c.pcOut = 1'b1;
            readReg(c, w);
            checkWord("pc after fetch", 32'h104 + 4 * k, w);
            c = '0;
            c.cOut = 1'b1;
            readReg(c, w);
            checkWord("immediate on bus", immExp[k], w);
        end

        repeat (2) @(negedge clk);
        if (chkExp.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("some results were never checked");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

//--- files.f
design/cpuPkg.sv
design/busPkg.sv
design/regFile.sv
design/arithUnit.sv
design/mulDivUnit.sv
design/aluCore.sv
design/datapath.sv
dv/datapathTb.sv

//--- Bender.yml
package:
  name: datapath

sources:
  - design/cpuPkg.sv
  - design/busPkg.sv
  - design/regFile.sv
  - design/arithUnit.sv
  - design/mulDivUnit.sv
  - design/aluCore.sv
  - design/datapath.sv
  - target: simulation
    files:
      - dv/datapathTb.sv
